//--- filelist.f
+incdir+hw
hw/mad_pkg.sv
hw/multicycle_path.sv
hw/mad_multicycled.sv
hw/sram_multicycled.sv
hw/host_port.sv
hw/mad_system.sv
verification/mad_system_tb.sv

//--- hw/host_port.sv
`timescale 1ns/1ps

`include "mad_config.svh"

// Four-phase req/ack command port in front of the MAD and SRAM units
module host_port import mad_pkg::*; (
	input  logic					MCLK,
	input  logic					nRST,

	// Host side
	input  logic					cmd_req,
	input  mad_cmd_t				cmd,
	output logic					cmd_ack,
	output mad_resp_t				resp,
	output logic					busy,

	// MAD unit
	output logic					mad_ie,
	output mad_operands_t			mad_operands,
	input  logic					mad_iready,
	input  logic					mad_oe,
	input  logic [`MAD_DATA_W-1:0]	mad_result,

	// SRAM unit
	output logic					sram_ie,
	output sram_req_t				sram_req,
	input  logic					sram_iready,
	input  logic					sram_oe,
	input  logic [`MAD_DATA_W-1:0]	sram_rdata
);

	typedef enum logic [1:0] {
		ST_IDLE	= 2'd0,
		ST_WAIT	= 2'd1,
		ST_ACK	= 2'd2
	} state_e;

	state_e		state_q;
	logic		is_mad;
	logic		is_sram;
	logic		idle_req;

	// ----------------------------------------------------------------------
	// Command decode and payload build
	// ----------------------------------------------------------------------
	assign is_mad	= (cmd.op == OP_MAD);
	assign is_sram	= (cmd.op == OP_WRITE) || (cmd.op == OP_READ);
	assign idle_req	= (state_q == ST_IDLE) && cmd_req;

	assign mad_operands.a	= cmd.a;
	assign mad_operands.b	= cmd.b;
	assign mad_operands.c	= cmd.c;

	// Address from low bits of a, data from b
	assign sram_req.we		= (cmd.op == OP_WRITE);
	assign sram_req.addr	= cmd.a[`MAD_ADDR_W-1:0];
	assign sram_req.wdata	= cmd.b;

	// Issue strobes, one cycle since the FSM leaves idle on that edge
	assign mad_ie	= idle_req && is_mad && mad_iready;
	assign sram_ie	= idle_req && is_sram && sram_iready;

	assign cmd_ack	= (state_q == ST_ACK);
	assign busy		= (state_q != ST_IDLE);

	// ----------------------------------------------------------------------
	// Handshake FSM
	// ----------------------------------------------------------------------
	always_ff @(posedge MCLK or negedge nRST) begin
		if (!nRST) begin
			state_q	<= ST_IDLE;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (mad_ie || sram_ie)
						state_q	<= ST_WAIT;
					else if (idle_req && !is_mad && !is_sram)
						state_q	<= ST_ACK;	// unknown op is acked with no work
				end
				ST_WAIT: begin
					if (mad_oe || sram_oe)
						state_q	<= ST_ACK;
				end
				// Held while the host keeps cmd_req high
				ST_ACK: begin
					if (!cmd_req)
						state_q	<= ST_IDLE;
				end
				default: state_q	<= ST_IDLE;
			endcase
		end
	end

	// Response capture, only one unit is ever in flight
	always_ff @(posedge MCLK) begin
		if (state_q == ST_WAIT) begin
			if (mad_oe)
				resp.data	<= mad_result;
			else if (sram_oe)
				resp.data	<= sram_rdata;
		end
	end

endmodule

//--- hw/mad_config.svh
`ifndef MAD_CONFIG_SVH
`define MAD_CONFIG_SVH

// ----------------------------------------------------------------------
// Datapath sizing
// ----------------------------------------------------------------------
// Operand and result width
`define MAD_DATA_W		64
// SRAM address width and word count, kept consistent by hand
`define MAD_ADDR_W		10
`define MAD_SRAM_DEPTH	1024

// ----------------------------------------------------------------------
// Multi-cycle timing
// ----------------------------------------------------------------------
// Clock cycles each multi-cycle path is given to settle
`define MAD_MCP_CYCLE	3

`endif

//--- hw/mad_multicycled.sv
`timescale 1ns/1ps

`include "mad_config.svh"

// A*B+C with the multiply-add given MAD_MCP_CYCLE cycles to settle
module mad_multicycled import mad_pkg::*; (
	input  logic					MCLK,
	input  logic					nRST,
	input  logic					ie,
	input  mad_operands_t			operands,
	output logic					iready,
	output logic					oe,
	output logic [`MAD_DATA_W-1:0]	result
);

	mad_operands_t				held;
	logic						path_oe;
	logic [`MAD_DATA_W-1:0]		mad_sum;

	multicycle_path #(
		.CYCLE		(`MAD_MCP_CYCLE),
		.payload_t	(mad_operands_t)
	) mcp_i (
		.MCLK		(MCLK),
		.nRST		(nRST),
		.ie			(ie),
		.iready		(iready),
		.din		(operands),
		.dout		(held),
		.oe			(path_oe)
	);

	// Slow path, low 64 bits only
	assign mad_sum = held.a * held.b + held.c;

	// Sampled only at the edge closing the window
	always_ff @(posedge MCLK) begin
		if (path_oe)
			result	<= mad_sum;
	end

	always_ff @(posedge MCLK or negedge nRST) begin
		if (!nRST)
			oe	<= 1'b0;
		else
			oe	<= path_oe;
	end

endmodule

//--- hw/mad_pkg.sv
package mad_pkg;

	`include "mad_config.svh"

	// Host command codes, 2'b11 is unused
	typedef enum logic [1:0] {
		OP_MAD		= 2'd0,
		OP_WRITE	= 2'd1,
		OP_READ		= 2'd2
	} mad_op_e;

	// Host command
	// SRAM commands take the address from low bits of a and data from b
	typedef struct packed {
		mad_op_e					op;
		logic [`MAD_DATA_W-1:0]		a;
		logic [`MAD_DATA_W-1:0]		b;
		logic [`MAD_DATA_W-1:0]		c;
	} mad_cmd_t;

	// Multiply-add operands, the MAD payload
	typedef struct packed {
		logic [`MAD_DATA_W-1:0]		a;
		logic [`MAD_DATA_W-1:0]		b;
		logic [`MAD_DATA_W-1:0]		c;
	} mad_operands_t;

	// SRAM access, the SRAM payload
	typedef struct packed {
		logic						we;
		logic [`MAD_ADDR_W-1:0]		addr;
		logic [`MAD_DATA_W-1:0]		wdata;
	} sram_req_t;

	// Result returned to the host
	typedef struct packed {
		logic [`MAD_DATA_W-1:0]		data;
	} mad_resp_t;

endpackage

//--- hw/mad_system.sv
`timescale 1ns/1ps

`include "mad_config.svh"

// Multiply-add and SRAM subsystem behind a four-phase host port
module mad_system import mad_pkg::*; (
	input  logic		MCLK,
	input  logic		nRST,
	input  logic		cmd_req,
	input  mad_cmd_t	cmd,
	output logic		cmd_ack,
	output mad_resp_t	resp,
	output logic		busy
);

	// ----------------------------------------------------------------------
	// Unit links
	// ----------------------------------------------------------------------
	logic						mad_ie;
	mad_operands_t				mad_operands;
	logic						mad_iready;
	logic						mad_oe;
	logic [`MAD_DATA_W-1:0]		mad_result;

	logic						sram_ie;
	sram_req_t					sram_req;
	logic						sram_iready;
	logic						sram_oe;
	logic [`MAD_DATA_W-1:0]		sram_rdata;

	host_port host_port_i (
		.MCLK			(MCLK),
		.nRST			(nRST),
		.cmd_req		(cmd_req),
		.cmd			(cmd),
		.cmd_ack		(cmd_ack),
		.resp			(resp),
		.busy			(busy),
		.mad_ie			(mad_ie),
		.mad_operands	(mad_operands),
		.mad_iready		(mad_iready),
		.mad_oe			(mad_oe),
		.mad_result		(mad_result),
		.sram_ie		(sram_ie),
		.sram_req		(sram_req),
		.sram_iready	(sram_iready),
		.sram_oe		(sram_oe),
		.sram_rdata		(sram_rdata)
	);

	mad_multicycled mad_i (
		.MCLK		(MCLK),
		.nRST		(nRST),
		.ie			(mad_ie),
		.operands	(mad_operands),
		.iready		(mad_iready),
		.oe			(mad_oe),
		.result		(mad_result)
	);

	sram_multicycled sram_i (
		.MCLK		(MCLK),
		.nRST		(nRST),
		.ie			(sram_ie),
		.req		(sram_req),
		.iready		(sram_iready),
		.oe			(sram_oe),
		.rdata		(sram_rdata)
	);

endmodule

//--- hw/multicycle_path.sv
`timescale 1ns/1ps

// Holds a payload stable for CYCLE cycles so that logic behind dout
// may take that many cycles to settle
module multicycle_path #(
	parameter int CYCLE = 2,
	parameter type payload_t = logic [7:0]
) (
	input  logic		MCLK,
	input  logic		nRST,
	input  logic		ie,
	output logic		iready,
	input  payload_t	din,
	output payload_t	dout,
	output logic		oe
);

	// Counter is at least one bit wide even for CYCLE of 1
	localparam int CNT_W = (CYCLE > 1) ? $clog2(CYCLE) : 1;

	logic				busy_q;
	logic [CNT_W-1:0]	cnt_q;
	logic				accept;

	// ----------------------------------------------------------------------
	// Window control
	// ----------------------------------------------------------------------
	// Final cycle of the window, sampled by the edge that closes it
	assign oe		= busy_q && (cnt_q == '0);
	// Free again once the last cycle is reached
	assign iready	= !busy_q || oe;
	assign accept	= ie && iready;

	always_ff @(posedge MCLK or negedge nRST) begin
		if (!nRST) begin
			busy_q	<= 1'b0;
			cnt_q	<= '0;
		end else if (accept) begin
			// New window starts, a fresh item overrides a closing one
			busy_q	<= 1'b1;
			cnt_q	<= CNT_W'(CYCLE - 1);
		end else if (busy_q) begin
			if (cnt_q == '0)
				busy_q	<= 1'b0;
			else
				cnt_q	<= cnt_q - 1'b1;
		end
	end

	// ----------------------------------------------------------------------
	// Payload hold
	// ----------------------------------------------------------------------
	// Stays put until the next accepted item
	always_ff @(posedge MCLK) begin
		if (accept)
			dout	<= din;
	end

endmodule

//--- hw/sram_multicycled.sv
`timescale 1ns/1ps

`include "mad_config.svh"

// Single-port SRAM whose access is given MAD_MCP_CYCLE cycles
module sram_multicycled import mad_pkg::*; (
	input  logic					MCLK,
	input  logic					nRST,
	input  logic					ie,
	input  sram_req_t				req,
	output logic					iready,
	output logic					oe,
	output logic [`MAD_DATA_W-1:0]	rdata
);

	sram_req_t					held;
	logic						path_oe;

	// Storage array
	logic [`MAD_DATA_W-1:0]		mem [0:`MAD_SRAM_DEPTH-1];

	// ----------------------------------------------------------------------
	// Request hold
	// ----------------------------------------------------------------------
	// Address and write data stay stable for the whole access window
	multicycle_path #(
		.CYCLE		(`MAD_MCP_CYCLE),
		.payload_t	(sram_req_t)
	) mcp_i (
		.MCLK		(MCLK),
		.nRST		(nRST),
		.ie			(ie),
		.iready		(iready),
		.din		(req),
		.dout		(held),
		.oe			(path_oe)
	);

	// ----------------------------------------------------------------------
	// Array access
	// ----------------------------------------------------------------------
	// Acts only on the last edge of the window
	always_ff @(posedge MCLK) begin
		if (path_oe) begin
			if (held.we)
				mem[held.addr]	<= held.wdata;
			else
				rdata			<= mem[held.addr];
		end
	end

	// Completion strobe, for writes as well as reads
	always_ff @(posedge MCLK or negedge nRST) begin
		if (!nRST)
			oe	<= 1'b0;
		else
			oe	<= path_oe;
	end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, result decided from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module mad_system_tb \
	-Mdir obj_dir -o mad_system_sim > build.log 2>&1 \
	|| { echo "Build failed, see build.log"; exit 1; }

./obj_dir/mad_system_sim > sim.log 2>&1
cat sim.log

grep -q "CHECKS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation passed"

//--- verification/mad_system_tb.sv
`timescale 1ns/1ps

`include "mad_config.svh"

module mad_system_tb import mad_pkg::*; ();

	localparam int CLK_PERIOD	= 10;
	localparam int MAX_WAIT		= `MAD_MCP_CYCLE + 10;
	// Commands issued by all tests, rounded up, plus margin for reset and holds
	localparam int NUM_CMDS		= 60;
	localparam int WATCHDOG_NS	= (NUM_CMDS * MAX_WAIT + 100) * CLK_PERIOD;

	logic		MCLK;
	logic		nRST;
	logic		cmd_req;
	mad_cmd_t	cmd;
	logic		cmd_ack;
	mad_resp_t	resp;
	logic		busy;

	int			errors;
	int			checks;
	// Timing seen by the last transaction
	int			ack_edges;
	int			fall_edges;
	bit			busy_ok;
	bit			hold_ok;

	mad_system dut_i (
		.MCLK		(MCLK),
		.nRST		(nRST),
		.cmd_req	(cmd_req),
		.cmd		(cmd),
		.cmd_ack	(cmd_ack),
		.resp		(resp),
		.busy		(busy)
	);

	initial MCLK = 1'b0;
	always #(CLK_PERIOD / 2) MCLK = ~MCLK;

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired, the run took longer than its time limit");
		$display("CHECKS FAILED");
		$finish;
	end

	// ----------------------------------------------------------------------
	// One four-phase transaction, driven on falling edges
	// ----------------------------------------------------------------------
	task automatic do_cmd(input mad_op_e op, input logic [63:0] a, input logic [63:0] b,
			input logic [63:0] c, input int hold, output logic [63:0] data);
		int n;
		@(negedge MCLK);
		cmd.op	= op;
		cmd.a	= a;
		cmd.b	= b;
		cmd.c	= c;
		cmd_req	= 1'b1;
		busy_ok	= 1'b1;
		hold_ok	= 1'b1;
		n		= 0;
		// First falling edge follows the issuing edge
		while (!cmd_ack && n < MAX_WAIT) begin
			@(negedge MCLK);
			n++;
			if (!busy)
				busy_ok = 1'b0;
		end
		ack_edges	= n - 1;
		data		= resp.data;
		if (!cmd_ack) begin
			errors++;
			$display("cmd_ack never rose within %0d cycles of cmd_req", MAX_WAIT);
		end
		// Host keeps cmd_req up, ack and response must hold
		repeat (hold) begin
			@(negedge MCLK);
			if (!cmd_ack || resp.data !== data)
				hold_ok = 1'b0;
		end
		cmd_req	= 1'b0;
		n		= 0;
		while (cmd_ack && n < MAX_WAIT) begin
			@(negedge MCLK);
			n++;
		end
		fall_edges = n;
		if (cmd_ack) begin
			errors++;
			$display("cmd_ack never fell after cmd_req was dropped");
		end
	endtask

	// ----------------------------------------------------------------------
	// Directed tests
	// ----------------------------------------------------------------------
	task automatic reset_state();
		checks++;
		if (cmd_ack !== 1'b0 || busy !== 1'b0) begin
			errors++;
			$display("[ERROR] reset_state: expected ack 0 busy 0, actual ack %b busy %b",
				cmd_ack, busy);
		end
	endtask

	task automatic mad_directed();
		logic [63:0] a;
		logic [63:0] exp;
		logic [63:0] got;
		// Operand sets (3,4,5), (5,6,7) up to (19,20,21)
		for (int i = 0; i < 9; i++) begin
			a	= 64'(3 + 2 * i);
			exp	= a * (a + 64'd1) + (a + 64'd2);
			do_cmd(OP_MAD, a, a + 64'd1, a + 64'd2, 0, got);
			checks++;
			if (got !== exp) begin
				errors++;
				$display("[ERROR] mad_directed: expected %0d, actual %0d", exp, got);
			end
		end
	endtask

	task automatic mad_random();
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] c;
		logic [63:0] exp;
		logic [63:0] got;
		for (int i = 0; i < 20; i++) begin
			a	= {$urandom, $urandom};
			b	= {$urandom, $urandom};
			c	= {$urandom, $urandom};
			// Keep low 64 bits only
			exp	= a * b + c;
			do_cmd(OP_MAD, a, b, c, 0, got);
			checks++;
			if (got !== exp) begin
				errors++;
				$display("[ERROR] mad_random: expected %h, actual %h", exp, got);
			end
		end
	endtask

	task automatic sram_write_read();
		logic [63:0]	model [int];
		int				addrs [$];
		int				addr;
		logic [63:0]	data;
		logic [63:0]	got;
		for (int i = 0; i < 8; i++) begin
			addr	= int'($urandom % `MAD_SRAM_DEPTH);
			data	= {$urandom, $urandom};
			do_cmd(OP_WRITE, 64'(addr), data, 64'd0, 0, got);
			model[addr] = data;
			addrs.push_back(addr);
		end
		// Repeated addresses read back the latest value
		foreach (addrs[i]) begin
			do_cmd(OP_READ, 64'(addrs[i]), 64'd0, 64'd0, 0, got);
			checks++;
			if (got !== model[addrs[i]]) begin
				errors++;
				$display("[ERROR] sram_write_read: addr %0d expected %h, actual %h",
					addrs[i], model[addrs[i]], got);
			end
		end
		// Overwrite of a used address
		data = ~model[addrs[0]];
		do_cmd(OP_WRITE, 64'(addrs[0]), data, 64'd0, 0, got);
		do_cmd(OP_READ, 64'(addrs[0]), 64'd0, 64'd0, 0, got);
		checks++;
		if (got !== data) begin
			errors++;
			$display("[ERROR] sram_write_read: overwrite expected %h, actual %h", data, got);
		end
	endtask

	task automatic handshake_timing();
		logic [63:0] got;
		do_cmd(OP_MAD, 64'd6, 64'd7, 64'd8, 5, got);
		checks++;
		if (ack_edges != `MAD_MCP_CYCLE + 1) begin
			errors++;
			$display("[ERROR] handshake_timing: expected ack after %0d edges, actual %0d",
				`MAD_MCP_CYCLE + 1, ack_edges);
		end
		checks++;
		if (!busy_ok || !hold_ok || fall_edges != 1) begin
			errors++;
			$display("busy dropped, ack did not hold or ack fell late in handshake_timing");
		end
		checks++;
		if (got !== 64'd50 || busy !== 1'b0) begin
			errors++;
			$display("[ERROR] handshake_timing: expected 50 busy 0, actual %0d busy %b",
				got, busy);
		end
	endtask

	// ----------------------------------------------------------------------
	// Sequence
	// ----------------------------------------------------------------------
	initial begin
		errors	= 0;
		checks	= 0;
		void'($urandom(15));
		nRST	= 1'b0;
		cmd_req	= 1'b0;
		cmd		= '0;
		repeat (2) @(posedge MCLK);
		@(negedge MCLK);
		nRST	= 1'b1;
		reset_state();
		mad_directed();
		mad_random();
		sram_write_read();
		handshake_timing();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule
